/* logic/miss_unit_defs.svh */
`ifndef MISS_UNIT_DEFS_SVH
`define MISS_UNIT_DEFS_SVH

// number of outstanding load misses
`define MSHR_DEPTH 8

// dirty lines waiting for the memory bus
`define EVICT_DEPTH 4

// one line is a single 64-bit word, so 32-bit byte address minus 3 offset bits
`define LINE_ADDR_BITS 29

// memory transaction tag, zero means no transaction
`define MEM_TAG_BITS 4

`endif

/* logic/miss_unit_pkg.sv */
`include "miss_unit_defs.svh"

package miss_unit_pkg;

  typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

  // same encoding as the memory model expects
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } mem_cmd_e;

  // request on the memory command bus
  typedef struct packed {
    mem_cmd_e    command;
    line_addr_t  addr;
    logic [63:0] data;
  } mem_req_t;

  // completed miss returned to the cache
  typedef struct packed {
    line_addr_t  addr;
    logic [63:0] data;
  } fill_t;

  // dirty line leaving the cache
  typedef struct packed {
    line_addr_t  addr;
    logic [63:0] data;
  } evict_t;

  // miss entry lifecycle
  typedef enum logic [1:0] {
    empty       = 2'd0,
    waiting     = 2'd1,
    in_progress = 2'd2,
    done        = 2'd3
  } mshr_state_e;

endpackage

/* logic/mshr_queue.sv */
`timescale 1ns/1ps
`include "miss_unit_defs.svh"

module mshr_queue (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [1:0]                      miss_en,
  input  miss_unit_pkg::line_addr_t [1:0] miss_addr,
  input  logic                            stored,
  input  logic                            accepted,
  input  logic [`MEM_TAG_BITS-1:0]        response_tag,
  input  logic [`MEM_TAG_BITS-1:0]        mem2proc_tag,
  input  logic [63:0]                     mem2proc_data,
  input  miss_unit_pkg::line_addr_t [1:0] search_addr,
  output logic                            mshr_full,
  output miss_unit_pkg::mem_req_t         request,
  output miss_unit_pkg::fill_t            fill,
  output logic                            fill_valid,
  output logic [1:0]                      search_hit
);

  localparam int PTR_BITS = $clog2(`MSHR_DEPTH);

  // per-entry state is control, the rest is payload
  miss_unit_pkg::mshr_state_e state [`MSHR_DEPTH];
  miss_unit_pkg::line_addr_t  entry_addr [`MSHR_DEPTH];
  logic [63:0]                entry_data [`MSHR_DEPTH];
  logic [`MEM_TAG_BITS-1:0]   entry_tag [`MSHR_DEPTH];

  // allocate at the tail, issue in the middle, retire at the head
  logic [PTR_BITS-1:0]    alloc_ptr;
  logic [PTR_BITS-1:0]    issue_ptr;
  logic [PTR_BITS-1:0]    retire_ptr;
  logic [PTR_BITS-1:0]    second_slot;
  logic [PTR_BITS:0]      used_count;
  logic [PTR_BITS:0]      free_count;
  logic [1:0]             alloc_count;
  logic                   retire;
  logic [`MSHR_DEPTH-1:0] tag_match;

  assign alloc_count = {1'b0, miss_en[0]} + {1'b0, miss_en[1]};

  // port 1 lands behind port 0 only when both strobe
  assign second_slot = alloc_ptr + PTR_BITS'(miss_en[0]);

  assign free_count = (PTR_BITS + 1)'(`MSHR_DEPTH) - used_count;
  assign mshr_full  = free_count < (PTR_BITS + 1)'(2);

  // oldest entry goes back to the cache once its data is in
  assign fill_valid = state[retire_ptr] == miss_unit_pkg::done;
  assign fill.addr  = entry_addr[retire_ptr];
  assign fill.data  = entry_data[retire_ptr];
  assign retire     = fill_valid & stored;

  // next unissued load, held until memory gives it a tag
  always_comb begin
    request.command = miss_unit_pkg::bus_none;
    if (state[issue_ptr] == miss_unit_pkg::waiting) begin
      request.command = miss_unit_pkg::bus_load;
    end
    request.addr = entry_addr[issue_ptr];
    request.data = '0;
  end

  // returns may arrive in any order
  always_comb begin
    for (int i = 0; i < `MSHR_DEPTH; i++) begin
      tag_match[i] = (state[i] == miss_unit_pkg::in_progress) &&
                     (mem2proc_tag != '0) &&
                     (entry_tag[i] == mem2proc_tag);
    end
  end

  // pending line lookup for both cache ports
  always_comb begin
    search_hit = '0;
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        if (state[i] != miss_unit_pkg::empty && entry_addr[i] == search_addr[p]) begin
          search_hit[p] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        state[i] <= miss_unit_pkg::empty;
      end
      alloc_ptr  <= '0;
      issue_ptr  <= '0;
      retire_ptr <= '0;
      used_count <= '0;
    end else begin
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        if (tag_match[i]) begin
          state[i] <= miss_unit_pkg::done;
        end
      end
      if (accepted) begin
        state[issue_ptr] <= miss_unit_pkg::in_progress;
      end
      if (retire) begin
        state[retire_ptr] <= miss_unit_pkg::empty;
      end
      // new entries are always empty slots, no overlap with the above
      if (miss_en[0]) begin
        state[alloc_ptr] <= miss_unit_pkg::waiting;
      end
      if (miss_en[1]) begin
        state[second_slot] <= miss_unit_pkg::waiting;
      end
      alloc_ptr  <= alloc_ptr + PTR_BITS'(alloc_count);
      issue_ptr  <= issue_ptr + PTR_BITS'(accepted);
      retire_ptr <= retire_ptr + PTR_BITS'(retire);
      used_count <= used_count + (PTR_BITS + 1)'(alloc_count) - (PTR_BITS + 1)'(retire);
    end
  end

  always_ff @(posedge clock) begin
    if (miss_en[0]) begin
      entry_addr[alloc_ptr] <= miss_addr[0];
    end
    if (miss_en[1]) begin
      entry_addr[second_slot] <= miss_addr[1];
    end
    if (accepted) begin
      entry_tag[issue_ptr] <= response_tag;
    end
    for (int i = 0; i < `MSHR_DEPTH; i++) begin
      if (tag_match[i]) begin
        entry_data[i] <= mem2proc_data;
      end
    end
  end

endmodule

/* logic/evict_buffer.sv */
`timescale 1ns/1ps
`include "miss_unit_defs.svh"

module evict_buffer (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            evict_en,
  input  miss_unit_pkg::evict_t           evict,
  input  logic                            accepted,
  input  miss_unit_pkg::line_addr_t [1:0] search_addr,
  output logic                            evict_full,
  output miss_unit_pkg::mem_req_t         request,
  output logic [1:0]                      search_data_valid,
  output logic [1:0][63:0]                search_data
);

  localparam int PTR_BITS = $clog2(`EVICT_DEPTH);

  miss_unit_pkg::evict_t slots [`EVICT_DEPTH];

  logic [PTR_BITS-1:0] head_ptr;
  logic [PTR_BITS-1:0] tail_ptr;
  logic [PTR_BITS:0]   count;

  assign evict_full = count == (PTR_BITS + 1)'(`EVICT_DEPTH);

  // head goes out as a store whenever anything is queued
  assign request.command = (count != '0) ? miss_unit_pkg::bus_store : miss_unit_pkg::bus_none;
  assign request.addr    = slots[head_ptr].addr;
  assign request.data    = slots[head_ptr].data;

  // walk oldest to newest so the newest match is the one left standing
  always_comb begin
    search_data_valid = '0;
    search_data       = '0;
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < `EVICT_DEPTH; k++) begin
        if (k < count && slots[head_ptr + PTR_BITS'(k)].addr == search_addr[p]) begin
          search_data_valid[p] = 1'b1;
          search_data[p]       = slots[head_ptr + PTR_BITS'(k)].data;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      head_ptr <= head_ptr + PTR_BITS'(accepted);
      tail_ptr <= tail_ptr + PTR_BITS'(evict_en);
      count    <= count + (PTR_BITS + 1)'(evict_en) - (PTR_BITS + 1)'(accepted);
    end
  end

  always_ff @(posedge clock) begin
    if (evict_en) begin
      slots[tail_ptr] <= evict;
    end
  end

endmodule

/* logic/mem_bus_arbiter.sv */
`timescale 1ns/1ps
`include "miss_unit_defs.svh"

module mem_bus_arbiter (
  input  logic                     clock,
  input  logic                     reset,
  input  miss_unit_pkg::mem_req_t  load_request,
  input  miss_unit_pkg::mem_req_t  store_request,
  input  logic [`MEM_TAG_BITS-1:0] mem2proc_response,
  output miss_unit_pkg::mem_req_t  proc2mem,
  output logic                     load_accepted,
  output logic                     store_accepted,
  output logic [`MEM_TAG_BITS-1:0] response_tag
);

  logic load_req;
  logic store_req;
  logic grant_store;
  logic accepted;
  // round-robin pointer, high means store has priority
  logic rr_store;
  // a rejected winner keeps the bus until accepted
  logic hold;
  logic hold_store;

  assign load_req  = load_request.command != miss_unit_pkg::bus_none;
  assign store_req = store_request.command != miss_unit_pkg::bus_none;

  always_comb begin
    if (hold) begin
      grant_store = hold_store;
    end else begin
      grant_store = store_req && (!load_req || rr_store);
    end
  end

  always_comb begin
    proc2mem = '{command: miss_unit_pkg::bus_none, addr: '0, data: '0};
    if (grant_store) begin
      proc2mem = store_request;
    end else if (load_req) begin
      proc2mem = load_request;
    end
  end

  assign accepted       = (mem2proc_response != '0) && (proc2mem.command != miss_unit_pkg::bus_none);
  assign response_tag   = mem2proc_response;
  assign load_accepted  = accepted && !grant_store;
  assign store_accepted = accepted && grant_store;

  always_ff @(posedge clock) begin
    if (reset) begin
      rr_store   <= 1'b0;
      hold       <= 1'b0;
      hold_store <= 1'b0;
    end else begin
      if (accepted) begin
        rr_store <= !grant_store;
      end
      hold       <= (proc2mem.command != miss_unit_pkg::bus_none) && !accepted;
      hold_store <= grant_store;
    end
  end

endmodule

/* logic/miss_unit_top.sv */
`timescale 1ns/1ps
`include "miss_unit_defs.svh"

module miss_unit_top (
  input  logic                            clock,
  input  logic                            reset,
  // cache side
  input  logic [1:0]                      miss_en,
  input  miss_unit_pkg::line_addr_t [1:0] miss_addr,
  output logic                            mshr_full,
  output miss_unit_pkg::fill_t            fill,
  output logic                            fill_valid,
  input  logic                            stored,
  input  logic                            evict_en,
  input  miss_unit_pkg::evict_t           evict,
  output logic                            evict_full,
  input  miss_unit_pkg::line_addr_t [1:0] search_addr,
  output logic [1:0]                      search_hit,
  output logic [1:0]                      search_data_valid,
  output logic [1:0][63:0]                search_data,
  // memory side
  output miss_unit_pkg::mem_req_t         proc2mem,
  input  logic [`MEM_TAG_BITS-1:0]        mem2proc_response,
  input  logic [`MEM_TAG_BITS-1:0]        mem2proc_tag,
  input  logic [63:0]                     mem2proc_data
);

  miss_unit_pkg::mem_req_t  load_request;
  miss_unit_pkg::mem_req_t  store_request;
  logic                     load_accepted;
  logic                     store_accepted;
  logic [`MEM_TAG_BITS-1:0] response_tag;

  mshr_queue queue0 (
    .clock         (clock),
    .reset         (reset),
    .miss_en       (miss_en),
    .miss_addr     (miss_addr),
    .stored        (stored),
    .accepted      (load_accepted),
    .response_tag  (response_tag),
    .mem2proc_tag  (mem2proc_tag),
    .mem2proc_data (mem2proc_data),
    .search_addr   (search_addr),
    .mshr_full     (mshr_full),
    .request       (load_request),
    .fill          (fill),
    .fill_valid    (fill_valid),
    .search_hit    (search_hit)
  );

  evict_buffer evict0 (
    .clock             (clock),
    .reset             (reset),
    .evict_en          (evict_en),
    .evict             (evict),
    .accepted          (store_accepted),
    .search_addr       (search_addr),
    .evict_full        (evict_full),
    .request           (store_request),
    .search_data_valid (search_data_valid),
    .search_data       (search_data)
  );

  mem_bus_arbiter arbiter0 (
    .clock             (clock),
    .reset             (reset),
    .load_request      (load_request),
    .store_request     (store_request),
    .mem2proc_response (mem2proc_response),
    .proc2mem          (proc2mem),
    .load_accepted     (load_accepted),
    .store_accepted    (store_accepted),
    .response_tag      (response_tag)
  );

endmodule

/* dv/miss_unit_asserts.sv */
`timescale 1ns/1ps
`include "miss_unit_defs.svh"

module miss_unit_asserts (
  input logic                     clock,
  input logic                     reset,
  input logic [1:0]               miss_en,
  input logic                     mshr_full,
  input miss_unit_pkg::fill_t     fill,
  input logic                     fill_valid,
  input logic                     stored,
  input miss_unit_pkg::mem_req_t  proc2mem,
  input logic [`MEM_TAG_BITS-1:0] mem2proc_response
);

  int error_count = 0;

  // memory said no, so the same request comes back
  held_request: assert property (@(posedge clock) disable iff (reset)
      (proc2mem.command != miss_unit_pkg::bus_none && mem2proc_response == '0)
      |=> $stable(proc2mem))
    else begin
      error_count++;
      $error("rejected bus request changed before acceptance");
    end

  // fill is a level until the cache takes it
  stable_fill: assert property (@(posedge clock) disable iff (reset)
      (fill_valid && !stored) |=> (fill_valid && $stable(fill)))
    else begin
      error_count++;
      $error("fill changed or dropped before stored");
    end

  no_miss_when_full: assert property (@(posedge clock) disable iff (reset)
      !(miss_en != '0 && mshr_full))
    else begin
      error_count++;
      $error("miss strobed while the miss queue was full");
    end

endmodule

bind miss_unit_top miss_unit_asserts asserts0 (.*);

/* dv/mem_responder.sv */
`timescale 1ns/1ps
`include "miss_unit_defs.svh"

module mem_responder (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [31:0]              rand_word,
  input  miss_unit_pkg::mem_req_t  proc2mem,
  output logic [`MEM_TAG_BITS-1:0] mem2proc_response,
  output logic [`MEM_TAG_BITS-1:0] mem2proc_tag,
  output logic [63:0]              mem2proc_data
);

  localparam int NUM_TAGS = 1 << `MEM_TAG_BITS;

  // sparse store image, unwritten lines read as a hash
  logic [63:0]              image [miss_unit_pkg::line_addr_t];
  logic                     busy [NUM_TAGS];
  logic [63:0]              load_data [NUM_TAGS];
  int                       delay [NUM_TAGS];
  logic [`MEM_TAG_BITS-1:0] next_tag;

  function automatic logic [63:0] line_hash(input miss_unit_pkg::line_addr_t addr);
    return ({35'h0, addr} * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a5a_0ff0_c33c_1234;
  endfunction

  always @(posedge clock) begin
    logic [`MEM_TAG_BITS-1:0] t;
    bit                       sent;
    if (reset) begin
      mem2proc_response <= '0;
      mem2proc_tag      <= '0;
      mem2proc_data     <= '0;
      next_tag = 1;
      for (int i = 0; i < NUM_TAGS; i++) begin
        busy[i] = 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_TAGS; i++) begin
        if (busy[i] && delay[i] > 0) begin
          delay[i]--;
        end
      end
      // transfer taken during the cycle that just ended
      if (proc2mem.command != miss_unit_pkg::bus_none && mem2proc_response != '0) begin
        t = mem2proc_response;
        if (proc2mem.command == miss_unit_pkg::bus_store) begin
          image[proc2mem.addr] = proc2mem.data;
        end else begin
          busy[t]      = 1'b1;
          delay[t]     = 1 + int'(rand_word[10:8]) % 7;
          load_data[t] = image.exists(proc2mem.addr) ? image[proc2mem.addr]
                                                     : line_hash(proc2mem.addr);
        end
        next_tag = (next_tag == `MEM_TAG_BITS'(NUM_TAGS - 1)) ? 1 : next_tag + 1;
      end
      // one return per cycle, scan starts at a random slot
      sent = 1'b0;
      mem2proc_tag <= '0;
      for (int k = 0; k < NUM_TAGS; k++) begin
        t = rand_word[19:16] + `MEM_TAG_BITS'(k);
        if (!sent && busy[t] && delay[t] == 0) begin
          mem2proc_tag  <= t;
          mem2proc_data <= load_data[t];
          busy[t] = 1'b0;
          sent    = 1'b1;
        end
      end
      mem2proc_response <= (rand_word[1:0] != 2'b00 && !busy[next_tag]) ? next_tag : '0;
    end
  end

endmodule

/* dv/tb_miss_unit.sv */
`timescale 1ns/1ps
`include "miss_unit_defs.svh"

module tb_miss_unit;

  localparam int NUM_MISSES = 300;
  localparam int NUM_EVICTS = 150;
  // forty cycles per transaction leaves room for the stall windows
  localparam int MAX_CYCLES = 40 * (NUM_MISSES + NUM_EVICTS) + 2000;

  logic                            clock = 1'b0;
  logic                            reset;
  logic [1:0]                      miss_en;
  miss_unit_pkg::line_addr_t [1:0] miss_addr;
  logic                            mshr_full;
  miss_unit_pkg::fill_t            fill;
  logic                            fill_valid;
  logic                            stored;
  logic                            evict_en;
  miss_unit_pkg::evict_t           evict;
  logic                            evict_full;
  miss_unit_pkg::line_addr_t [1:0] search_addr;
  logic [1:0]                      search_hit;
  logic [1:0]                      search_data_valid;
  logic [1:0][63:0]                search_data;
  miss_unit_pkg::mem_req_t         proc2mem;
  logic [`MEM_TAG_BITS-1:0]        mem2proc_response;
  logic [`MEM_TAG_BITS-1:0]        mem2proc_tag;
  logic [63:0]                     mem2proc_data;
  logic [31:0]                     rand_word;
  logic [31:0]                     lcg_state = 32'h609b_2495;

  // reference model
  miss_unit_pkg::fill_t  expected_fills [$];
  miss_unit_pkg::evict_t pending_evicts [$];
  logic [63:0]           image [miss_unit_pkg::line_addr_t];
  int                    cycle_count = 0;
  int                    misses_sent = 0;
  int                    evicts_sent = 0;
  int                    fills_done = 0;
  int                    stores_done = 0;

  miss_unit_top dut0 (.*);
  mem_responder mem0 (.*);

  always #20 clock = ~clock;

  initial begin
    reset       = 1'b1;
    miss_en     = '0;
    miss_addr   = '0;
    stored      = 1'b0;
    evict_en    = 1'b0;
    evict       = '0;
    search_addr = '0;
    rand_word   = '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // sixteen lines so that hits and repeats are common
  function automatic miss_unit_pkg::line_addr_t pool_addr(input logic [31:0] r);
    return {25'h0a5_3c4, r[31:28]};
  endfunction

  function automatic logic [63:0] memory_value(input miss_unit_pkg::line_addr_t addr);
    if (image.exists(addr)) begin
      return image[addr];
    end
    return mem0.line_hash(addr);
  endfunction

  function automatic bit miss_pending(input miss_unit_pkg::line_addr_t addr);
    foreach (expected_fills[i]) begin
      if (expected_fills[i].addr == addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // newest copy wins
  function automatic bit evict_lookup(input miss_unit_pkg::line_addr_t addr,
                                      output logic [63:0] data);
    bit found;
    found = 1'b0;
    data  = '0;
    foreach (pending_evicts[i]) begin
      if (pending_evicts[i].addr == addr) begin
        found = 1'b1;
        data  = pending_evicts[i].data;
      end
    end
    return found;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "miss unit testbench stopped");
  endtask

  task automatic compare_fill(input string name, input miss_unit_pkg::fill_t exp,
                              input miss_unit_pkg::fill_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic compare_store(input string name, input miss_unit_pkg::mem_req_t exp,
                               input miss_unit_pkg::mem_req_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic compare_search(input string name, input bit exp_valid,
                                input logic [63:0] exp_data, input logic act_valid,
                                input logic [63:0] act_data);
    if (act_valid !== exp_valid || (exp_valid && act_data !== exp_data)) begin
      stop_run($sformatf("FAILED %s expected %b/%h actual %b/%h", name,
                         exp_valid, exp_data, act_valid, act_data));
    end
  endtask

  task automatic compare_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  always @(posedge clock) begin
    logic [31:0]               r;
    logic [63:0]               fwd;
    bit                        found;
    bit                        stall_window;
    miss_unit_pkg::line_addr_t a;
    miss_unit_pkg::line_addr_t new_addr [2];
    bit                        new_valid [2];
    miss_unit_pkg::mem_req_t   exp_store;
    miss_unit_pkg::fill_t      exp_fill;
    if (!reset) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
        stop_run($sformatf("run timed out after %0d cycles", MAX_CYCLES));
      end
      if (dut0.asserts0.error_count != 0) begin
        stop_run("bound assertions reported protocol errors");
      end
      // outputs here belong to the cycle that just ended
      if (cycle_count == 1) begin
        compare_flag("reset_bus_idle", 1'b1, proc2mem.command == miss_unit_pkg::bus_none);
        compare_flag("reset_fill_valid", 1'b0, fill_valid);
      end
      compare_flag("mshr_full", (`MSHR_DEPTH - expected_fills.size()) < 2, mshr_full);
      compare_flag("evict_full", pending_evicts.size() == `EVICT_DEPTH, evict_full);
      for (int p = 0; p < 2; p++) begin
        compare_search("search_hit", miss_pending(search_addr[p]), '0, search_hit[p], '0);
        found = evict_lookup(search_addr[p], fwd);
        compare_search("search_forward", found, fwd, search_data_valid[p], search_data[p]);
      end
      if (fill_valid) begin
        if (expected_fills.size() == 0) begin
          stop_run("fill_valid was raised with no miss outstanding");
        end
        compare_fill("fill_in_order", expected_fills[0], fill);
        if (stored) begin
          void'(expected_fills.pop_front());
          fills_done++;
        end
      end
      if (proc2mem.command == miss_unit_pkg::bus_store && mem2proc_response != '0) begin
        if (pending_evicts.size() == 0) begin
          stop_run("a store went out on the bus with no eviction pending");
        end
        exp_store = '{command: miss_unit_pkg::bus_store, addr: pending_evicts[0].addr,
                      data: pending_evicts[0].data};
        compare_store("store_order", exp_store, proc2mem);
        void'(pending_evicts.pop_front());
        stores_done++;
      end
      // strobes of the ending cycle enter the model
      for (int p = 0; p < 2; p++) begin
        if (miss_en[p]) begin
          exp_fill = '{addr: miss_addr[p], data: memory_value(miss_addr[p])};
          expected_fills.push_back(exp_fill);
        end
      end
      if (evict_en) begin
        pending_evicts.push_back(evict);
        image[evict.addr] = evict.data;
      end
      // next cycle, model now matches the DUT after this edge
      miss_en   <= '0;
      evict_en  <= 1'b0;
      stored    <= 1'b0;
      rand_word <= next_rand();
      r = next_rand();
      stall_window = (cycle_count % 500) >= 200 && (cycle_count % 500) < 300;
      for (int p = 0; p < 2; p++) begin
        new_valid[p] = 1'b0;
        a = pool_addr(next_rand());
        if (r[31 - p] && misses_sent < NUM_MISSES &&
            (`MSHR_DEPTH - expected_fills.size()) >= 2 && !evict_lookup(a, fwd)) begin
          miss_en[p]   <= 1'b1;
          miss_addr[p] <= a;
          new_addr[p]  = a;
          new_valid[p] = 1'b1;
          misses_sent++;
        end
      end
      a = pool_addr(next_rand());
      if (r[29:28] == 2'b00 && evicts_sent < NUM_EVICTS &&
          pending_evicts.size() < `EVICT_DEPTH && !miss_pending(a) &&
          !(new_valid[0] && new_addr[0] == a) && !(new_valid[1] && new_addr[1] == a)) begin
        evict_en <= 1'b1;
        evict    <= '{addr: a, data: {next_rand(), next_rand()}};
        evicts_sent++;
      end
      if (fill_valid && !stored && !stall_window && r[27:26] != 2'b00) begin
        stored <= 1'b1;
      end
      for (int p = 0; p < 2; p++) begin
        search_addr[p] <= pool_addr(next_rand());
      end
      if (fills_done == NUM_MISSES && stores_done == NUM_EVICTS) begin
        $display("Test OK");
        $finish;
      end
    end
  end

endmodule

/* tb.f */
+incdir+logic
logic/miss_unit_pkg.sv
logic/mshr_queue.sv
logic/evict_buffer.sv
logic/mem_bus_arbiter.sv
logic/miss_unit_top.sv
dv/miss_unit_asserts.sv
dv/mem_responder.sv
dv/tb_miss_unit.sv
